/* Bender.yml */
package:
  name: spi_counter

sources:
  - hdl/spi_counter_pkg.sv
  - hdl/spi_rx_shifter.sv
  - hdl/spi_tx_shifter.sv
  - hdl/uptime_counter.sv
  - hdl/cmd_ctrl.sv
  - hdl/spi_counter_top.sv
  - target: test
    files:
      - tb/spi_counter_assertions.sv
      - tb/spi_counter_tb.sv

/* hdl/cmd_ctrl.sv */
// cmd_ctrl: frame tracking FSM, opcode decode, led register, clear and capture pulses
`default_nettype none

module cmd_ctrl (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               frame_start,
  input  logic                               frame_end,
  input  logic                               byte_valid,
  input  logic [spi_counter_pkg::BYTE_W-1:0] rx_byte,
  output logic                               capture,
  output logic                               count_clear,
  output logic                               led
);
  import spi_counter_pkg::*;

  frame_state_e state;
  cmd_opcode_e  cmd_q;

  ////////////////////////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////////////////////////

  // capture goes out the cycle after frame_start
  // fixed latency, readback differences depend on it
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= ST_IDLE;
      capture <= 1'b0;
      led     <= 1'b0;
    end
    else
    begin
      capture <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (frame_start)
          begin
            state   <= ST_FRAME;
            capture <= 1'b1;
          end
        end
        ST_FRAME:
        begin
          if (frame_end)
            state <= ST_IDLE;
          else if (byte_valid)
            state <= ST_EXEC;
        end
        ST_EXEC:
        begin
          // led updates here; clear is decoded below
          case (cmd_q)
            CMD_LED_ON:  led <= 1'b1;
            CMD_LED_OFF: led <= 1'b0;
            default:     led <= led;
          endcase
          // ssel may already be gone by now
          state <= frame_end ? ST_IDLE : ST_FRAME;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // command register and clear
  ////////////////////////////////////////////////////////////

  // hold the byte for the exec cycle
  always_ff @(posedge clk)
  begin
    if (byte_valid)
      cmd_q <= cmd_opcode_e'(rx_byte);
  end

  // one cycle high in exec, unknown bytes fall through
  assign count_clear = (state == ST_EXEC) && (cmd_q == CMD_CLEAR);

endmodule

`default_nettype wire

/* hdl/spi_counter_pkg.sv */
// shared widths, synchronizer depth, opcode and frame state enums
`default_nettype none

package spi_counter_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // one command byte per frame
  localparam int BYTE_W = 8;

  // uptime counter and readback word
  localparam int COUNT_W = 32;

  // stages on the sck and ssel chains
  // mosi runs one stage shorter
  localparam int SYNC_DEPTH = 3;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // command bytes from the master
  typedef enum logic [BYTE_W-1:0] {
    CMD_CLEAR   = 8'hCC,
    CMD_LED_ON  = 8'hCD,
    CMD_LED_OFF = 8'hCE
  } cmd_opcode_e;

  // control FSM states
  // exec lasts one cycle per received byte
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FRAME,
    ST_EXEC
  } frame_state_e;

endpackage

`default_nettype wire

/* hdl/spi_counter_top.sv */
// spi_counter_top: spi slave pins wired to rx/tx shifters, uptime counter and control FSM
`default_nettype none

module spi_counter_top (
  input  logic clk,
  input  logic rst,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,
  output logic led
);
  import spi_counter_pkg::*;

  ////////////////////////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////////////////////////

  logic              frame_start;
  logic              frame_end;
  logic              sck_fall;
  logic              byte_valid;
  logic [BYTE_W-1:0] rx_byte;
  logic              capture;
  logic              count_clear;
  logic [COUNT_W-1:0] count;

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////

  // pins in, frame and byte events out
  spi_rx_shifter rx_shifter_inst (
    .clk         (clk),
    .rst         (rst),
    .sck         (sck),
    .ssel        (ssel),
    .mosi        (mosi),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .sck_fall    (sck_fall),
    .byte_valid  (byte_valid),
    .rx_byte     (rx_byte)
  );

  // control
  cmd_ctrl cmd_ctrl_inst (
    .clk         (clk),
    .rst         (rst),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .byte_valid  (byte_valid),
    .rx_byte     (rx_byte),
    .capture     (capture),
    .count_clear (count_clear),
    .led         (led)
  );

  // uptime
  uptime_counter uptime_counter_inst (
    .clk         (clk),
    .rst         (rst),
    .count_clear (count_clear),
    .count       (count)
  );

  // readback to miso, single slave so no tri-state
  spi_tx_shifter tx_shifter_inst (
    .clk      (clk),
    .rst      (rst),
    .capture  (capture),
    .sck_fall (sck_fall),
    .count    (count),
    .miso     (miso)
  );

endmodule

`default_nettype wire

/* hdl/spi_rx_shifter.sv */
// spi_rx_shifter: pin synchronizers, sck/ssel edge detect, mosi byte assembly
`default_nettype none

module spi_rx_shifter (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               sck,
  input  logic                               ssel,
  input  logic                               mosi,
  output logic                               frame_start,
  output logic                               frame_end,
  output logic                               sck_fall,
  output logic                               byte_valid,
  output logic [spi_counter_pkg::BYTE_W-1:0] rx_byte
);
  import spi_counter_pkg::*;

  ////////////////////////////////////////////////////////////
  // synchronizers
  ////////////////////////////////////////////////////////////

  logic [SYNC_DEPTH-1:0]     sck_sync;
  logic [SYNC_DEPTH-1:0]     ssel_sync;
  logic [SYNC_DEPTH-2:0]     mosi_sync;
  logic                      sck_rise;
  logic                      ssel_active;
  logic [$clog2(BYTE_W)-1:0] bit_cnt;

  // idle bus values on reset: sck low, ssel high
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sck_sync  <= '0;
      ssel_sync <= '1;
      mosi_sync <= '0;
    end
    else
    begin
      sck_sync  <= {sck_sync[SYNC_DEPTH-2:0], sck};
      ssel_sync <= {ssel_sync[SYNC_DEPTH-2:0], ssel};
      mosi_sync <= {mosi_sync[SYNC_DEPTH-3:0], mosi};
    end
  end

  // edges come from the two oldest stages
  assign sck_rise    = (sck_sync[SYNC_DEPTH-1:SYNC_DEPTH-2] == 2'b01);
  assign ssel_active = ~ssel_sync[SYNC_DEPTH-2];

  // ssel is active low, so the frame opens on its falling edge
  assign frame_start = (ssel_sync[SYNC_DEPTH-1:SYNC_DEPTH-2] == 2'b10);
  assign frame_end   = (ssel_sync[SYNC_DEPTH-1:SYNC_DEPTH-2] == 2'b01);

  // tx side only shifts while selected
  assign sck_fall = ssel_active && (sck_sync[SYNC_DEPTH-1:SYNC_DEPTH-2] == 2'b10);

  ////////////////////////////////////////////////////////////
  // byte assembly
  ////////////////////////////////////////////////////////////

  // bit counter parked at zero between frames
  // so a cut-off byte never carries into the next frame
  always_ff @(posedge clk)
  begin
    if (rst || !ssel_active)
      bit_cnt <= '0;
    else if (sck_rise)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // msb first, shift left
  always_ff @(posedge clk)
  begin
    if (ssel_active && sck_rise)
      rx_byte <= {rx_byte[BYTE_W-2:0], mosi_sync[SYNC_DEPTH-2]};
  end

  // pulse one cycle after the 8th rising edge
  always_ff @(posedge clk)
  begin
    if (rst)
      byte_valid <= 1'b0;
    else
      byte_valid <= ssel_active && sck_rise && (bit_cnt == BYTE_W - 1);
  end

endmodule

`default_nettype wire

/* hdl/spi_tx_shifter.sv */
// spi_tx_shifter: readback word register shifted out msb first on miso
`default_nettype none

module spi_tx_shifter (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                capture,
  input  logic                                sck_fall,
  input  logic [spi_counter_pkg::COUNT_W-1:0] count,
  output logic                                miso
);
  import spi_counter_pkg::*;

  ////////////////////////////////////////////////////////////
  // readback shift register
  ////////////////////////////////////////////////////////////

  logic [COUNT_W-1:0] tx_word;

  // capture wins over a shift in the same cycle
  // zero fill once the word has gone out
  always_ff @(posedge clk)
  begin
    if (rst)
      tx_word <= '0;
    else if (capture)
      tx_word <= count;
    else if (sck_fall)
      tx_word <= {tx_word[COUNT_W-2:0], 1'b0};
  end

  // master samples before each rising sck,
  // the bit changes after the falling one
  assign miso = tx_word[COUNT_W-1];

endmodule

`default_nettype wire

/* hdl/uptime_counter.sv */
// uptime_counter: free-running wrapping counter with synchronous clear
`default_nettype none

module uptime_counter (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                count_clear,
  output logic [spi_counter_pkg::COUNT_W-1:0] count
);
  import spi_counter_pkg::*;

  ////////////////////////////////////////////////////////////
  // counter
  ////////////////////////////////////////////////////////////

  // clear takes priority, zero shows the cycle after the pulse
  // otherwise one step per clk, wraps at all ones
  always_ff @(posedge clk)
  begin
    if (rst || count_clear)
      count <= '0;
    else
      count <= count + COUNT_W'(1);
  end

endmodule

`default_nettype wire

/* spi_counter.f */
hdl/spi_counter_pkg.sv
hdl/spi_rx_shifter.sv
hdl/spi_tx_shifter.sv
hdl/uptime_counter.sv
hdl/cmd_ctrl.sv
hdl/spi_counter_top.sv
tb/spi_counter_assertions.sv
tb/spi_counter_tb.sv

/* tb/spi_counter_assertions.sv */
// spi_counter_assertions: unknown outputs, led timing, clear result, pulses under reset
`default_nettype none

module spi_counter_assertions (
  input logic                                clk,
  input logic                                rst,
  input logic                                led,
  input logic                                miso,
  input logic                                byte_valid,
  input logic                                capture,
  input logic                                count_clear,
  input logic [spi_counter_pkg::COUNT_W-1:0] count
);
  import spi_counter_pkg::*;

  // failed assertions so far
  int fail_count = 0;

  ////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////

  // outputs settle once reset has run
  a_no_x: assert property (@(posedge clk) disable iff (rst) !$isunknown({led, miso}))
    else
    begin
      fail_count++;
      $error("led or miso is unknown");
    end

  // led moves only in the exec window after a byte
  a_led_window: assert property (@(posedge clk) disable iff (rst)
    (led != $past(led)) |-> ($past(byte_valid, 1) || $past(byte_valid, 2)))
    else
    begin
      fail_count++;
      $error("led changed outside the window after byte_valid");
    end

  // clear lands in one cycle
  a_clear_zero: assert property (@(posedge clk) disable iff (rst)
    count_clear |=> (count == '0))
    else
    begin
      fail_count++;
      $error("count not zero after count_clear");
    end

  // no control pulses while held in reset
  a_quiet_in_reset: assert property (@(posedge clk)
    (rst && $past(rst)) |-> (!capture && !count_clear))
    else
    begin
      fail_count++;
      $error("capture or count_clear high during reset");
    end

endmodule

bind spi_counter_top spi_counter_assertions assertions_inst (
  .clk         (clk),
  .rst         (rst),
  .led         (led),
  .miso        (miso),
  .byte_valid  (byte_valid),
  .capture     (capture),
  .count_clear (count_clear),
  .count       (count)
);

`default_nettype wire

/* tb/spi_counter_tb.sv */
// testbench: clock, reset, spi master task, led/readback/clear/partial byte tests, timeout
`default_nettype none

module spi_counter_tb;
  import spi_counter_pkg::*;

  // frame length in clk: 4 setup, 12 per bit, 8 idle
  localparam int FRAME_8  = 4 + 12 * 8 + 8;
  localparam int FRAME_32 = 4 + 12 * 32 + 8;
  localparam int FRAME_5  = 4 + 12 * 5 + 8;
  // eight byte frames, four readbacks, one partial, plus reset and gaps
  localparam int RUN_SUM        = 8 * FRAME_8 + 4 * FRAME_32 + FRAME_5 + 200;
  localparam int TIMEOUT_CYCLES = 4 * RUN_SUM;

  logic clk;
  logic rst;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso;
  logic led;

  int cycle = 0;
  int err_count = 0;
  int seed;
  // cycle of the latest ssel fall and latest sck rise
  int start_cycle;
  int last_rise_cycle;
  int rb_a_start;
  int clear_rise;
  logic [COUNT_W-1:0] rb_a;
  logic [COUNT_W-1:0] rb_b;
  logic [COUNT_W-1:0] rb_pre;
  logic [COUNT_W-1:0] rb_post;
  logic [COUNT_W-1:0] scratch;
  logic [BYTE_W-1:0]  junk;

  spi_counter_top spi_counter_top_inst (
    .clk  (clk),
    .rst  (rst),
    .sck  (sck),
    .ssel (ssel),
    .mosi (mosi),
    .miso (miso),
    .led  (led)
  );

  always #20 clk = ~clk;

  // cycle count and run limit
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // land 2 units after the rising edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic expect_value(input string name, input longint expected, input longint actual);
    if (expected != actual)
    begin
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic expect_below(input string name, input longint bound, input longint actual);
    if (actual >= bound)
    begin
      $display("FAIL %s: expected below %0d, actual %0d", name, bound, actual);
      err_count++;
    end
  endtask

  // random byte that is none of the three opcodes
  task automatic draw_unknown_byte(output logic [BYTE_W-1:0] b);
    b = $random(seed);
    while (b == CMD_CLEAR || b == CMD_LED_ON || b == CMD_LED_OFF)
      b = $random(seed);
  endtask

  // mode 0 master, byte_out repeats every 8 bits, miso read before each rise
  task automatic transfer(input logic [BYTE_W-1:0] byte_out, input int n_bits,
                          output logic [COUNT_W-1:0] word_in);
    int i;
    word_in = '0;
    ssel = 1'b0;
    start_cycle = cycle;
    wait_clks(4);
    for (i = 0; i < n_bits; i++)
    begin
      mosi = byte_out[BYTE_W - 1 - (i % BYTE_W)];
      if (i < COUNT_W)
        word_in = {word_in[COUNT_W-2:0], miso};
      sck = 1'b1;
      last_rise_cycle = cycle;
      wait_clks(6);
      sck = 1'b0;
      wait_clks(6);
    end
    ssel = 1'b1;
    wait_clks(8);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    clk  = 1'b0;
    rst  = 1'b1;
    sck  = 1'b0;
    ssel = 1'b1;
    mosi = 1'b0;
    seed = 98;
    wait_clks(10);
    rst = 1'b0;
    wait_clks(2);

    // reset state
    expect_value("reset_led", 0, led);
    expect_value("reset_miso", 0, miso);

    // led on, unknown byte, led off, unknown byte
    transfer(CMD_LED_ON, 8, scratch);
    expect_value("led_on", 1, led);
    draw_unknown_byte(junk);
    transfer(junk, 8, scratch);
    expect_value("unknown_keeps_on", 1, led);
    transfer(CMD_LED_OFF, 8, scratch);
    expect_value("led_off", 0, led);
    draw_unknown_byte(junk);
    transfer(junk, 8, scratch);
    expect_value("unknown_keeps_off", 0, led);

    // two readbacks, value difference equals ssel fall distance
    transfer(8'h00, 32, rb_a);
    rb_a_start = start_cycle;
    wait_clks(37);
    transfer(8'h00, 32, rb_b);
    expect_value("readback_diff", start_cycle - rb_a_start, rb_b - rb_a);

    // clear, then read back after a short idle gap
    transfer(8'h00, 32, rb_pre);
    transfer(CMD_CLEAR, 8, scratch);
    clear_rise = last_rise_cycle;
    wait_clks(20);
    transfer(8'h00, 32, rb_post);
    expect_below("clear_bound", start_cycle - clear_rise + 8, rb_post);
    expect_below("clear_vs_pre", rb_pre / 4, rb_post);

    // led lit first so the off frame after the cut-off byte has to act
    transfer(CMD_LED_ON, 8, scratch);
    expect_value("on_before_partial", 1, led);

    // cut-off led on byte must not merge with the next frame
    transfer(CMD_LED_ON, 5, scratch);
    transfer(CMD_LED_OFF, 8, scratch);
    expect_value("partial_then_off", 0, led);
    transfer(CMD_LED_ON, 8, scratch);
    expect_value("full_on_after_partial", 1, led);

    wait_clks(4);
    $display("errors: %0d value mismatches, %0d assertion failures",
             err_count, spi_counter_top_inst.assertions_inst.fail_count);
    if (err_count == 0 && spi_counter_top_inst.assertions_inst.fail_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
